//--- rtl/axi_bus_if.sv
//////////////////////////////
// axi bus interface
// the five channels of one axi port, each with
// valid, ready and a struct payload
//////////////////////////////

`timescale 1ns/1ps

interface axi_bus_if;

  // write address channel
  logic                  aw_valid;
  logic                  aw_ready;
  axi_dly_pkg::ax_chan_t aw_chan;

  // write data channel
  logic                  w_valid;
  logic                  w_ready;
  axi_dly_pkg::w_chan_t  w_chan;

  // read address channel
  logic                  ar_valid;
  logic                  ar_ready;
  axi_dly_pkg::ax_chan_t ar_chan;

  // write response channel
  logic                  b_valid;
  logic                  b_ready;
  axi_dly_pkg::b_chan_t  b_chan;

  // read data channel
  logic                  r_valid;
  logic                  r_ready;
  axi_dly_pkg::r_chan_t  r_chan;

  // manager side drives the requests and accepts the responses
  modport mgr (
    output aw_valid, aw_chan, input  aw_ready,
    output w_valid,  w_chan,  input  w_ready,
    output ar_valid, ar_chan, input  ar_ready,
    input  b_valid,  b_chan,  output b_ready,
    input  r_valid,  r_chan,  output r_ready
  );

  // subordinate side is the mirror image
  modport sub (
    input  aw_valid, aw_chan, output aw_ready,
    input  w_valid,  w_chan,  output w_ready,
    input  ar_valid, ar_chan, output ar_ready,
    output b_valid,  b_chan,  input  b_ready,
    output r_valid,  r_chan,  input  r_ready
  );

endinterface

//--- rtl/axi_delay_top.sv
//////////////////////////////
// axi delay top
// plain upstream and downstream axi ports around
// the channel delayer
//////////////////////////////

`timescale 1ns/1ps

module axi_delay_top #(
  parameter bit StallRandomInput  = 1'b0,
  parameter int FixedDelayInput   = 1,
  parameter bit StallRandomOutput = 1'b0,
  parameter int FixedDelayOutput  = 1
) (
  input  logic                  clk,
  input  logic                  reset_i,
  // upstream port, the delayer is the subordinate here
  input  logic                  up_aw_valid_i,
  input  axi_dly_pkg::ax_chan_t up_aw_chan_i,
  output logic                  up_aw_ready_o,
  input  logic                  up_w_valid_i,
  input  axi_dly_pkg::w_chan_t  up_w_chan_i,
  output logic                  up_w_ready_o,
  input  logic                  up_ar_valid_i,
  input  axi_dly_pkg::ax_chan_t up_ar_chan_i,
  output logic                  up_ar_ready_o,
  output logic                  up_b_valid_o,
  output axi_dly_pkg::b_chan_t  up_b_chan_o,
  input  logic                  up_b_ready_i,
  output logic                  up_r_valid_o,
  output axi_dly_pkg::r_chan_t  up_r_chan_o,
  input  logic                  up_r_ready_i,
  // downstream port, the delayer is the manager here
  output logic                  dn_aw_valid_o,
  output axi_dly_pkg::ax_chan_t dn_aw_chan_o,
  input  logic                  dn_aw_ready_i,
  output logic                  dn_w_valid_o,
  output axi_dly_pkg::w_chan_t  dn_w_chan_o,
  input  logic                  dn_w_ready_i,
  output logic                  dn_ar_valid_o,
  output axi_dly_pkg::ax_chan_t dn_ar_chan_o,
  input  logic                  dn_ar_ready_i,
  input  logic                  dn_b_valid_i,
  input  axi_dly_pkg::b_chan_t  dn_b_chan_i,
  output logic                  dn_b_ready_o,
  input  logic                  dn_r_valid_i,
  input  axi_dly_pkg::r_chan_t  dn_r_chan_i,
  output logic                  dn_r_ready_o
);

  axi_bus_if up_bus ();
  axi_bus_if dn_bus ();

  // upstream side
  assign up_bus.aw_valid = up_aw_valid_i;
  assign up_bus.aw_chan  = up_aw_chan_i;
  assign up_aw_ready_o   = up_bus.aw_ready;
  assign up_bus.w_valid  = up_w_valid_i;
  assign up_bus.w_chan   = up_w_chan_i;
  assign up_w_ready_o    = up_bus.w_ready;
  assign up_bus.ar_valid = up_ar_valid_i;
  assign up_bus.ar_chan  = up_ar_chan_i;
  assign up_ar_ready_o   = up_bus.ar_ready;
  assign up_b_valid_o    = up_bus.b_valid;
  assign up_b_chan_o     = up_bus.b_chan;
  assign up_bus.b_ready  = up_b_ready_i;
  assign up_r_valid_o    = up_bus.r_valid;
  assign up_r_chan_o     = up_bus.r_chan;
  assign up_bus.r_ready  = up_r_ready_i;

  // downstream side
  assign dn_aw_valid_o   = dn_bus.aw_valid;
  assign dn_aw_chan_o    = dn_bus.aw_chan;
  assign dn_bus.aw_ready = dn_aw_ready_i;
  assign dn_w_valid_o    = dn_bus.w_valid;
  assign dn_w_chan_o     = dn_bus.w_chan;
  assign dn_bus.w_ready  = dn_w_ready_i;
  assign dn_ar_valid_o   = dn_bus.ar_valid;
  assign dn_ar_chan_o    = dn_bus.ar_chan;
  assign dn_bus.ar_ready = dn_ar_ready_i;
  assign dn_bus.b_valid  = dn_b_valid_i;
  assign dn_bus.b_chan   = dn_b_chan_i;
  assign dn_b_ready_o    = dn_bus.b_ready;
  assign dn_bus.r_valid  = dn_r_valid_i;
  assign dn_bus.r_chan   = dn_r_chan_i;
  assign dn_r_ready_o    = dn_bus.r_ready;

  axi_delayer #(
    .StallRandomInput  (StallRandomInput),
    .FixedDelayInput   (FixedDelayInput),
    .StallRandomOutput (StallRandomOutput),
    .FixedDelayOutput  (FixedDelayOutput)
  ) u_delayer (
    .clk               (clk),
    .reset_i           (reset_i),
    .slv               (up_bus.sub),
    .mst               (dn_bus.mgr)
  );

endmodule

//--- rtl/axi_delayer.sv
//////////////////////////////
// axi delayer
// one stream delay stage per axi channel, the
// requests share one stall setting and the
// responses share another
//////////////////////////////

`timescale 1ns/1ps

module axi_delayer #(
  parameter bit StallRandomInput  = 1'b0,
  parameter int FixedDelayInput   = 1,
  parameter bit StallRandomOutput = 1'b0,
  parameter int FixedDelayOutput  = 1
) (
  input  logic      clk,
  input  logic      reset_i,
  axi_bus_if.sub    slv,
  axi_bus_if.mgr    mst
);

  // write address, upstream to downstream
  stream_delay #(
    .payload_t   (axi_dly_pkg::ax_chan_t),
    .StallRandom (StallRandomInput),
    .FixedDelay  (FixedDelayInput),
    .Seed        (16'hACE1)
  ) u_aw_delay (
    .clk         (clk),
    .reset_i     (reset_i),
    .valid_i     (slv.aw_valid),
    .payload_i   (slv.aw_chan),
    .ready_o     (slv.aw_ready),
    .valid_o     (mst.aw_valid),
    .payload_o   (mst.aw_chan),
    .ready_i     (mst.aw_ready)
  );

  // write data
  stream_delay #(
    .payload_t   (axi_dly_pkg::w_chan_t),
    .StallRandom (StallRandomInput),
    .FixedDelay  (FixedDelayInput),
    .Seed        (16'h1D2B)
  ) u_w_delay (
    .clk         (clk),
    .reset_i     (reset_i),
    .valid_i     (slv.w_valid),
    .payload_i   (slv.w_chan),
    .ready_o     (slv.w_ready),
    .valid_o     (mst.w_valid),
    .payload_o   (mst.w_chan),
    .ready_i     (mst.w_ready)
  );

  // read address
  stream_delay #(
    .payload_t   (axi_dly_pkg::ax_chan_t),
    .StallRandom (StallRandomInput),
    .FixedDelay  (FixedDelayInput),
    .Seed        (16'h7A35)
  ) u_ar_delay (
    .clk         (clk),
    .reset_i     (reset_i),
    .valid_i     (slv.ar_valid),
    .payload_i   (slv.ar_chan),
    .ready_o     (slv.ar_ready),
    .valid_o     (mst.ar_valid),
    .payload_o   (mst.ar_chan),
    .ready_i     (mst.ar_ready)
  );

  // write response flows back from downstream to upstream
  stream_delay #(
    .payload_t   (axi_dly_pkg::b_chan_t),
    .StallRandom (StallRandomOutput),
    .FixedDelay  (FixedDelayOutput),
    .Seed        (16'h5C3F)
  ) u_b_delay (
    .clk         (clk),
    .reset_i     (reset_i),
    .valid_i     (mst.b_valid),
    .payload_i   (mst.b_chan),
    .ready_o     (mst.b_ready),
    .valid_o     (slv.b_valid),
    .payload_o   (slv.b_chan),
    .ready_i     (slv.b_ready)
  );

  // read data
  stream_delay #(
    .payload_t   (axi_dly_pkg::r_chan_t),
    .StallRandom (StallRandomOutput),
    .FixedDelay  (FixedDelayOutput),
    .Seed        (16'h9E47)
  ) u_r_delay (
    .clk         (clk),
    .reset_i     (reset_i),
    .valid_i     (mst.r_valid),
    .payload_i   (mst.r_chan),
    .ready_o     (mst.r_ready),
    .valid_o     (slv.r_valid),
    .payload_o   (slv.r_chan),
    .ready_i     (slv.r_ready)
  );

endmodule

//--- rtl/axi_dly_pkg.sv
//////////////////////////////
// axi delay package
// widths and reduced channel payload structs for
// the axi delay stage, shared by the RTL and the testbench
//////////////////////////////

package axi_dly_pkg;

  // bus widths
  parameter int ID_W   = 4;
  parameter int ADDR_W = 32;
  parameter int DATA_W = 32;
  parameter int STRB_W = DATA_W / 8;

  // a random stall count is 0 to 2**DELAY_W - 1 cycles
  parameter int DELAY_W = 4;

  // address channel payload, used for both AW and AR
  typedef struct packed {
    logic [ID_W-1:0]   id;
    logic [ADDR_W-1:0] addr;
    logic [7:0]        len;
    logic [2:0]        size;
    logic [1:0]        burst;
  } ax_chan_t;

  // write data channel payload
  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic [STRB_W-1:0] strb;
    logic              last;
  } w_chan_t;

  // write response channel payload
  typedef struct packed {
    logic [ID_W-1:0] id;
    logic [1:0]      resp;
  } b_chan_t;

  // read data channel payload
  typedef struct packed {
    logic [ID_W-1:0]   id;
    logic [DATA_W-1:0] data;
    logic [1:0]        resp;
    logic              last;
  } r_chan_t;

endpackage

//--- rtl/stall_lfsr.sv
//////////////////////////////
// stall lfsr
// 16-bit galois lfsr giving a pseudo-random
// stall count, stepped once per transfer
//////////////////////////////

`timescale 1ns/1ps

module stall_lfsr #(
  parameter logic [15:0] Seed = 16'hACE1
) (
  input  logic                            clk,
  input  logic                            reset_i,
  input  logic                            step_i,
  output logic [axi_dly_pkg::DELAY_W-1:0] count_o
);

  // feedback mask for taps 16, 14, 13 and 11 in right-shift form
  localparam logic [15:0] TapMask = 16'hB400;

  logic [15:0] state;
  logic [15:0] state_next;

  // shift right and fold the output bit back into the tap positions
  assign state_next = {1'b0, state[15:1]} ^ (state[0] ? TapMask : 16'h0000);

  always_ff @(posedge clk) begin
    if (reset_i) begin
      state <= Seed;
    end else if (step_i) begin
      state <= state_next;
    end
  end

  assign count_o = state[axi_dly_pkg::DELAY_W-1:0];

endmodule

//--- rtl/stream_delay.sv
//////////////////////////////
// stream delay
// holds back one valid/ready channel for a fixed
// or pseudo-random number of cycles, payload passes
// through unchanged
//////////////////////////////

`timescale 1ns/1ps

module stream_delay #(
  parameter type         payload_t   = logic,
  parameter bit          StallRandom = 1'b0,
  parameter int          FixedDelay  = 1,
  parameter logic [15:0] Seed        = 16'hACE1
) (
  input  logic     clk,
  input  logic     reset_i,
  input  logic     valid_i,
  input  payload_t payload_i,
  output logic     ready_o,
  output logic     valid_o,
  output payload_t payload_o,
  input  logic     ready_i
);

  // the counter has to hold the largest stall this instance can see
  localparam int MaxStall = StallRandom ? (2 ** axi_dly_pkg::DELAY_W) - 1 : FixedDelay;
  localparam int CntW     = (MaxStall > 0) ? $clog2(MaxStall + 1) : 1;

  logic            busy;
  logic [CntW-1:0] cnt;
  logic [CntW-1:0] stall;
  logic            xfer;

  if (StallRandom) begin : g_random
    logic [axi_dly_pkg::DELAY_W-1:0] lfsr_count;

    // a new stall value is drawn after every completed transfer
    stall_lfsr #(
      .Seed    (Seed)
    ) u_lfsr (
      .clk     (clk),
      .reset_i (reset_i),
      .step_i  (xfer),
      .count_o (lfsr_count)
    );

    assign stall = CntW'(lfsr_count);
  end else begin : g_fixed
    assign stall = CntW'(FixedDelay);
  end

  // a zero stall lets valid through in the same cycle it arrives
  assign valid_o   = valid_i & (busy ? (cnt == '0) : (stall == '0));
  assign xfer      = valid_o & ready_i;
  assign ready_o   = xfer;
  assign payload_o = payload_i;

  // cnt holds the cycles still to wait after the current one
  always_ff @(posedge clk) begin
    if (reset_i) begin
      busy <= 1'b0;
      cnt  <= '0;
    end else if (!busy) begin
      if (valid_i && (stall != '0)) begin
        busy <= 1'b1;
        cnt  <= stall - CntW'(1);
      end
    end else if (cnt != '0) begin
      cnt <= cnt - CntW'(1);
    end else if (xfer) begin
      busy <= 1'b0;
    end
  end

endmodule

//--- src.f
rtl/axi_dly_pkg.sv
rtl/axi_bus_if.sv
rtl/stall_lfsr.sv
rtl/stream_delay.sv
rtl/axi_delayer.sv
rtl/axi_delay_top.sv
tb/tb_axi_delay_top.sv

//--- tb/tb_axi_delay_top.sv
//////////////////////////////
// axi delay testbench
// random axi traffic through the delay stage, with a
// manager driver, a subordinate responder and a
// scoreboard with order, handshake and timing checks
//////////////////////////////

`timescale 1ns/1ps

module tb_axi_delay_top;

  localparam int NumTxn     = 150;
  localparam int RespDelay  = 2;
  localparam int CycleLimit = 2 * NumTxn * 5 * 40;

  logic clk;
  logic reset_i;
  logic up_aw_valid_i, up_aw_ready_o, up_w_valid_i, up_w_ready_o;
  logic up_ar_valid_i, up_ar_ready_o, up_b_valid_o, up_b_ready_i;
  logic up_r_valid_o, up_r_ready_i;
  logic dn_aw_valid_o, dn_aw_ready_i, dn_w_valid_o, dn_w_ready_i;
  logic dn_ar_valid_o, dn_ar_ready_i, dn_b_valid_i, dn_b_ready_o;
  logic dn_r_valid_i, dn_r_ready_o;
  axi_dly_pkg::ax_chan_t up_aw_chan_i, up_ar_chan_i, dn_aw_chan_o, dn_ar_chan_o;
  axi_dly_pkg::w_chan_t  up_w_chan_i, dn_w_chan_o;
  axi_dly_pkg::b_chan_t  up_b_chan_o, dn_b_chan_i, b_hold_val;
  axi_dly_pkg::r_chan_t  up_r_chan_o, dn_r_chan_i, r_hold_val;

  // traffic generation state
  int aw_issued, ar_issued, w_left, r_left, r_beats, b_done, rlast_done, cycles;
  bit aw_fire, w_fire, ar_fire, b_fire, r_fire, b_held, r_held;
  bit resp_busy [2];
  int resp_age [2];
  int w_len_q [$];
  int rd_len_q [$];
  logic [axi_dly_pkg::ID_W-1:0] b_id_q [$];
  axi_dly_pkg::ax_chan_t rd_req_q [$];
  axi_dly_pkg::ax_chan_t cur_rd;

  // scoreboard, one queue per channel
  axi_dly_pkg::ax_chan_t aw_q [$];
  axi_dly_pkg::ax_chan_t ar_q [$];
  axi_dly_pkg::w_chan_t  w_q [$];
  axi_dly_pkg::b_chan_t  b_q [$];
  axi_dly_pkg::r_chan_t  r_q [$];

  axi_delay_top #(
    .StallRandomInput  (1'b1),
    .FixedDelayInput   (1),
    .StallRandomOutput (1'b0),
    .FixedDelayOutput  (RespDelay)
  ) DUT (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic abort_run();
    $display("Result: FAILED");
    $fatal(1, "simulation stopped at the first failure");
  endtask

  task automatic report_orphan(input string chan);
    $display("%s transfer left the delayer with no pending input", chan);
    abort_run();
  endtask

  task automatic check_ax(input string name, input axi_dly_pkg::ax_chan_t act,
                          input axi_dly_pkg::ax_chan_t exp);
    if (act !== exp) begin
      $display("error: %s is %h, expected %h", name, act, exp);
      abort_run();
    end
  endtask

  task automatic check_w(input string name, input axi_dly_pkg::w_chan_t act,
                         input axi_dly_pkg::w_chan_t exp);
    if (act !== exp) begin
      $display("error: %s is %h, expected %h", name, act, exp);
      abort_run();
    end
  endtask

  task automatic check_b(input string name, input axi_dly_pkg::b_chan_t act,
                         input axi_dly_pkg::b_chan_t exp);
    if (act !== exp) begin
      $display("error: %s is %h, expected %h", name, act, exp);
      abort_run();
    end
  endtask

  task automatic check_r(input string name, input axi_dly_pkg::r_chan_t act,
                         input axi_dly_pkg::r_chan_t exp);
    if (act !== exp) begin
      $display("error: %s is %h, expected %h", name, act, exp);
      abort_run();
    end
  endtask

  task automatic check_bit(input string name, input logic act, input logic exp);
    if (act !== exp) begin
      $display("error: %s is %h, expected %h", name, act, exp);
      abort_run();
    end
  endtask

  function automatic axi_dly_pkg::ax_chan_t random_ax();
    axi_dly_pkg::ax_chan_t ax;
    ax.id    = $urandom;
    ax.addr  = $urandom;
    ax.len   = $urandom_range(3);
    ax.size  = $urandom;
    ax.burst = $urandom;
    return ax;
  endfunction

  // with nothing sent yet every valid and ready output must be low
  task automatic check_quiet();
    check_bit("up_aw_ready_o", up_aw_ready_o, 1'b0);
    check_bit("up_w_ready_o", up_w_ready_o, 1'b0);
    check_bit("up_ar_ready_o", up_ar_ready_o, 1'b0);
    check_bit("up_b_valid_o", up_b_valid_o, 1'b0);
    check_bit("up_r_valid_o", up_r_valid_o, 1'b0);
    check_bit("dn_aw_valid_o", dn_aw_valid_o, 1'b0);
    check_bit("dn_w_valid_o", dn_w_valid_o, 1'b0);
    check_bit("dn_ar_valid_o", dn_ar_valid_o, 1'b0);
    check_bit("dn_b_ready_o", dn_b_ready_o, 1'b0);
    check_bit("dn_r_ready_o", dn_r_ready_o, 1'b0);
  endtask

  // a valid only changes once it is idle or has just been taken
  task automatic drive_manager();
    if (!up_aw_valid_i || aw_fire) begin
      up_aw_valid_i = 1'b0;
      if (aw_issued < NumTxn && $urandom_range(3) != 0) begin
        up_aw_chan_i  = random_ax();
        up_aw_valid_i = 1'b1;
        w_len_q.push_back(up_aw_chan_i.len + 1);
        aw_issued++;
      end
    end
    if (!up_w_valid_i || w_fire) begin
      up_w_valid_i = 1'b0;
      if (w_left == 0 && w_len_q.size() > 0) begin
        w_left = w_len_q.pop_front();
      end
      if (w_left > 0 && $urandom_range(3) != 0) begin
        up_w_chan_i.data = $urandom;
        up_w_chan_i.strb = $urandom;
        up_w_chan_i.last = (w_left == 1);
        up_w_valid_i     = 1'b1;
        w_left--;
      end
    end
    if (!up_ar_valid_i || ar_fire) begin
      up_ar_valid_i = 1'b0;
      if (ar_issued < NumTxn && $urandom_range(3) != 0) begin
        up_ar_chan_i  = random_ax();
        up_ar_valid_i = 1'b1;
        ar_issued++;
      end
    end
    up_b_ready_i = ($urandom_range(3) != 0);
    up_r_ready_i = ($urandom_range(3) != 0);
  endtask

  task automatic drive_subordinate();
    dn_aw_ready_i = $urandom_range(1);
    dn_w_ready_i  = $urandom_range(1);
    dn_ar_ready_i = $urandom_range(1);
    if (!dn_b_valid_i || b_fire) begin
      dn_b_valid_i = 1'b0;
      if (b_id_q.size() > 0 && $urandom_range(3) != 0) begin
        dn_b_chan_i.id   = b_id_q.pop_front();
        dn_b_chan_i.resp = $urandom;
        dn_b_valid_i     = 1'b1;
      end
    end
    if (!dn_r_valid_i || r_fire) begin
      dn_r_valid_i = 1'b0;
      if (r_left == 0 && rd_req_q.size() > 0) begin
        cur_rd = rd_req_q.pop_front();
        r_left = cur_rd.len + 1;
      end
      if (r_left > 0 && $urandom_range(3) != 0) begin
        dn_r_chan_i.id   = cur_rd.id;
        dn_r_chan_i.data = $urandom;
        dn_r_chan_i.resp = $urandom;
        dn_r_chan_i.last = (r_left == 1);
        dn_r_valid_i     = 1'b1;
        r_left--;
      end
    end
  endtask

  // a response valid shows up RespDelay cycles after it reaches an idle stage
  task automatic check_delay(input int ch, input string name, input logic vin,
                             input logic vout, input logic rdy);
    if (vin && !resp_busy[ch]) begin
      resp_busy[ch] = 1'b1;
      resp_age[ch]  = 0;
    end
    check_bit(name, vout, vin && (resp_age[ch] >= RespDelay));
    if (vout && rdy) begin
      resp_busy[ch] = 1'b0;
    end else if (resp_busy[ch]) begin
      resp_age[ch]++;
    end
  endtask

  always @(posedge clk) begin
    if (!reset_i) begin
      cycles++;
      if (cycles >= CycleLimit) begin
        $display("timeout, traffic did not finish within %0d cycles", CycleLimit);
        abort_run();
      end
      // input-side ready is the output-side transfer
      check_bit("up_aw_ready_o", up_aw_ready_o, dn_aw_valid_o & dn_aw_ready_i);
      check_bit("up_w_ready_o", up_w_ready_o, dn_w_valid_o & dn_w_ready_i);
      check_bit("up_ar_ready_o", up_ar_ready_o, dn_ar_valid_o & dn_ar_ready_i);
      check_bit("dn_b_ready_o", dn_b_ready_o, up_b_valid_o & up_b_ready_i);
      check_bit("dn_r_ready_o", dn_r_ready_o, up_r_valid_o & up_r_ready_i);
      aw_fire = up_aw_valid_i & up_aw_ready_o;
      w_fire  = up_w_valid_i & up_w_ready_o;
      ar_fire = up_ar_valid_i & up_ar_ready_o;
      b_fire  = dn_b_valid_i & dn_b_ready_o;
      r_fire  = dn_r_valid_i & dn_r_ready_o;
      if (aw_fire) aw_q.push_back(up_aw_chan_i);
      if (w_fire) w_q.push_back(up_w_chan_i);
      if (ar_fire) begin
        ar_q.push_back(up_ar_chan_i);
        rd_len_q.push_back(up_ar_chan_i.len + 1);
      end
      if (b_fire) b_q.push_back(dn_b_chan_i);
      if (r_fire) r_q.push_back(dn_r_chan_i);
      if (dn_aw_valid_o && dn_aw_ready_i) begin
        if (aw_q.size() == 0) begin
          report_orphan("AW");
        end else begin
          check_ax("dn_aw_chan_o", dn_aw_chan_o, aw_q.pop_front());
          b_id_q.push_back(dn_aw_chan_o.id);
        end
      end
      if (dn_w_valid_o && dn_w_ready_i) begin
        if (w_q.size() == 0) report_orphan("W");
        else check_w("dn_w_chan_o", dn_w_chan_o, w_q.pop_front());
      end
      if (dn_ar_valid_o && dn_ar_ready_i) begin
        if (ar_q.size() == 0) begin
          report_orphan("AR");
        end else begin
          check_ax("dn_ar_chan_o", dn_ar_chan_o, ar_q.pop_front());
          rd_req_q.push_back(dn_ar_chan_o);
        end
      end
      if (up_b_valid_o && up_b_ready_i) begin
        if (b_q.size() == 0) begin
          report_orphan("B");
        end else begin
          check_b("up_b_chan_o", up_b_chan_o, b_q.pop_front());
          b_done++;
        end
      end
      if (up_r_valid_o && up_r_ready_i) begin
        if (r_q.size() == 0 || rd_len_q.size() == 0) begin
          report_orphan("R");
        end else begin
          check_r("up_r_chan_o", up_r_chan_o, r_q.pop_front());
          r_beats++;
          check_bit("up_r_chan_o.last", up_r_chan_o.last, r_beats == rd_len_q[0]);
          if (up_r_chan_o.last) begin
            void'(rd_len_q.pop_front());
            r_beats = 0;
            rlast_done++;
          end
        end
      end
      // a stalled response must hold its payload
      if (b_held) check_b("up_b_chan_o", up_b_chan_o, b_hold_val);
      if (r_held) check_r("up_r_chan_o", up_r_chan_o, r_hold_val);
      b_held     = up_b_valid_o & ~up_b_ready_i;
      r_held     = up_r_valid_o & ~up_r_ready_i;
      b_hold_val = up_b_chan_o;
      r_hold_val = up_r_chan_o;
      check_delay(0, "up_b_valid_o", dn_b_valid_i, up_b_valid_o, up_b_ready_i);
      check_delay(1, "up_r_valid_o", dn_r_valid_i, up_r_valid_o, up_r_ready_i);
    end
  end

  initial begin
    void'($urandom(32'hfe1e94c9));
    reset_i       = 1'b1;
    up_aw_valid_i = 1'b0;
    up_w_valid_i  = 1'b0;
    up_ar_valid_i = 1'b0;
    up_b_ready_i  = 1'b0;
    up_r_ready_i  = 1'b0;
    dn_aw_ready_i = 1'b0;
    dn_w_ready_i  = 1'b0;
    dn_ar_ready_i = 1'b0;
    dn_b_valid_i  = 1'b0;
    dn_r_valid_i  = 1'b0;
    up_aw_chan_i  = '0;
    up_w_chan_i   = '0;
    up_ar_chan_i  = '0;
    dn_b_chan_i   = '0;
    dn_r_chan_i   = '0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    reset_i = 1'b0;
    repeat (3) begin
      @(posedge clk);
      check_quiet();
    end
    while (b_done < NumTxn || rlast_done < NumTxn || up_w_valid_i || w_left > 0 ||
           w_len_q.size() > 0) begin
      @(negedge clk);
      drive_manager();
      drive_subordinate();
    end
    up_aw_valid_i = 1'b0;
    up_w_valid_i  = 1'b0;
    up_ar_valid_i = 1'b0;
    dn_b_valid_i  = 1'b0;
    dn_r_valid_i  = 1'b0;
    // a few idle cycles expose any extra output transfer
    repeat (4) @(posedge clk);
    if (aw_q.size() == 0 && w_q.size() == 0 && ar_q.size() == 0 && b_q.size() == 0 &&
        r_q.size() == 0 && rd_len_q.size() == 0) begin
      $display("Result: PASSED");
      $finish;
    end else begin
      $display("scoreboard queues still hold items at the end of the run");
      abort_run();
    end
  end

endmodule
